// File: hdl/line_fsm.sv
// o_shact is one register after the delayed sync, so it keeps the delay line latency
// regeneration is chosen at line start only, a running line is never cut short
`timescale 1ns/100ps

module line_fsm (
  input  logic                    i_gclk_idata,
  input  logic                    i_reset_rq,
  input  sensor_phase_pkg::sync_t i_sync,       // from the delay line
  input  logic                    i_hact_regen,
  input  logic                    i_en_svact,
  input  logic                    i_line_done,  // last regenerated cycle
  input  logic                    i_holdoff_ok,
  output logic                    o_shact,
  output logic                    o_svact,
  output logic                    o_line_load,
  output logic                    o_frame_start
);

  sensor_phase_pkg::line_state_t state_q;
  sensor_phase_pkg::line_state_t state_d;
  logic                          hact_d;  // previous delayed hact
  logic                          vact_d;
  logic                          hact_rise;
  logic                          vact_rise;

  assign hact_rise = i_sync.hact && !hact_d;
  assign vact_rise = i_sync.vact && !vact_d;

  always_comb begin
    state_d     = state_q;
    o_line_load = 1'b0;
    case (state_q)
      sensor_phase_pkg::st_idle: begin
        if (hact_rise) begin
          if (i_hact_regen) begin
            state_d     = sensor_phase_pkg::st_regen;
            o_line_load = 1'b1;  // counter runs from the next cycle
          end else begin
            state_d = sensor_phase_pkg::st_follow;
          end
        end
      end
      sensor_phase_pkg::st_follow: if (!i_sync.hact) state_d = sensor_phase_pkg::st_idle;
      sensor_phase_pkg::st_regen:  if (i_line_done) state_d = sensor_phase_pkg::st_idle;
      default:                     state_d = sensor_phase_pkg::st_idle;
    endcase
  end

  // frame start needs the enable and an expired holdoff
  assign o_frame_start = vact_rise && i_en_svact && i_holdoff_ok;

  always_ff @(posedge i_gclk_idata or posedge i_reset_rq) begin
    if (i_reset_rq) begin
      state_q <= sensor_phase_pkg::st_idle;
      hact_d  <= 1'b0;
      vact_d  <= 1'b0;
      o_svact <= 1'b0;
    end else begin
      state_q <= state_d;
      hact_d  <= i_sync.hact;
      vact_d  <= i_sync.vact;
      o_svact <= o_frame_start;  // single cycle, same latency as o_shact
    end
  end

  assign o_shact = (state_q != sensor_phase_pkg::st_idle);

endmodule

// File: hdl/line_timer.sv
// line length 0 runs as 1, holdoff reads expired after reset
// holdoff spaces o_svact pulses by at least min_vact_period cycles
`timescale 1ns/100ps

module line_timer (
  input  logic                        i_gclk_idata,
  input  logic                        i_reset_rq,
  input  logic                        i_line_load,
  input  sensor_phase_pkg::line_len_t i_hact_length,
  input  logic                        i_frame_start,
  output logic                        o_line_done,
  output logic                        o_holdoff_ok
);

  sensor_phase_pkg::line_len_t line_cnt_q;  // remaining cycles, 0 when stopped
  sensor_phase_pkg::holdoff_t  hold_cnt_q;  // 0 means a new frame may start

  // line counter holds the length in the first active cycle
  always_ff @(posedge i_gclk_idata or posedge i_reset_rq) begin
    if (i_reset_rq) begin
      line_cnt_q <= '0;
    end else if (i_line_load) begin
      if (i_hact_length == '0) line_cnt_q <= 14'd1;
      else                     line_cnt_q <= i_hact_length;
    end else if (line_cnt_q != '0) begin
      line_cnt_q <= line_cnt_q - 14'd1;
    end
  end

  assign o_line_done = (line_cnt_q == 14'd1);  // last active cycle

  // strobe is one cycle ahead of o_svact, hence the reload of period - 1
  always_ff @(posedge i_gclk_idata or posedge i_reset_rq) begin
    if (i_reset_rq) begin
      hold_cnt_q <= '0;
    end else if (i_frame_start) begin
      hold_cnt_q <= sensor_phase_pkg::holdoff_t'(sensor_phase_pkg::min_vact_period - 1);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 8'd1;
    end
  end

  assign o_holdoff_ok = (hold_cnt_q == '0);

endmodule

// File: hdl/phase_regs.sv
// APB slave without wait states, writes land at the end of the access cycle
// unmapped offsets answer with pslverr and are ignored on write, read back as 0
`timescale 1ns/100ps

module phase_regs (
  input  logic                        i_gclk_idata,
  input  logic                        i_reset_rq,
  input  logic                        i_psel,
  input  logic                        i_penable,
  input  logic                        i_pwrite,
  input  sensor_phase_pkg::apb_addr_t i_paddr,
  input  sensor_phase_pkg::apb_data_t i_pwdata,
  output sensor_phase_pkg::apb_data_t o_prdata,
  output logic                        o_pready,
  output logic                        o_pslverr,
  output sensor_phase_pkg::ctrl_t     o_ctrl
);

  logic                          access;   // second cycle of a transfer
  logic                          addr_ok;
  logic                          wr_en;
  sensor_phase_pkg::phase_cmd_t  cmd;

  assign access  = i_psel && i_penable;
  assign addr_ok = (i_paddr == sensor_phase_pkg::addr_phase) ||
                   (i_paddr == sensor_phase_pkg::addr_mode) ||
                   (i_paddr == sensor_phase_pkg::addr_length);
  assign wr_en   = access && i_pwrite && addr_ok;
  assign cmd     = sensor_phase_pkg::phase_cmd_t'(i_pwdata[1:0]);  // low bits only

  assign o_pready  = 1'b1;                // never stalls
  assign o_pslverr = access && !addr_ok;

  always_ff @(posedge i_gclk_idata or posedge i_reset_rq) begin
    if (i_reset_rq) begin
      o_ctrl <= '0;  // phase 0, mode_10, regen and svact off, length 0
    end else if (wr_en) begin
      case (i_paddr)
        sensor_phase_pkg::addr_phase: begin
          case (cmd)
            sensor_phase_pkg::cmd_inc:   o_ctrl.phase <= o_ctrl.phase + 3'd1;  // wraps 7 -> 0
            sensor_phase_pkg::cmd_dec:   o_ctrl.phase <= o_ctrl.phase - 3'd1;  // wraps 0 -> 7
            sensor_phase_pkg::cmd_reset: o_ctrl.phase <= '0;
            default:                     o_ctrl.phase <= o_ctrl.phase;         // nop
          endcase
        end
        sensor_phase_pkg::addr_mode: begin
          o_ctrl.pix_mode   <= sensor_phase_pkg::pix_mode_t'(i_pwdata[1:0]);
          o_ctrl.hact_regen <= i_pwdata[2];
          o_ctrl.en_svact   <= i_pwdata[3];
        end
        default: o_ctrl.hact_length <= i_pwdata[13:0];  // only addr_length is left
      endcase
    end
  end

  // unused read bits stay zero
  always_comb begin
    o_prdata = '0;
    case (i_paddr)
      sensor_phase_pkg::addr_phase: o_prdata[2:0] = o_ctrl.phase;
      sensor_phase_pkg::addr_mode: begin
        o_prdata[1:0] = o_ctrl.pix_mode;
        o_prdata[2]   = o_ctrl.hact_regen;
        o_prdata[3]   = o_ctrl.en_svact;
      end
      sensor_phase_pkg::addr_length: o_prdata[13:0] = o_ctrl.hact_length;
      default: o_prdata = '0;
    endcase
  end

endmodule

// File: hdl/pixel_packer.sv
// three register stages from pins to o_sdo, latency does not depend on mode
// an unknown mode code packs as 10-bit
`timescale 1ns/100ps

module pixel_packer (
  input  logic                        i_gclk_idata,
  input  logic                        i_reset_rq,
  input  sensor_phase_pkg::raw_pix_t  i_di,
  input  sensor_phase_pkg::sync_t     i_sync,     // raw pins, same sample as i_di
  input  sensor_phase_pkg::pix_mode_t i_pix_mode,
  output sensor_phase_pkg::pix_t      o_sdo
);

  sensor_phase_pkg::raw_pix_t di_q;    // stage 1
  sensor_phase_pkg::sync_t    sync_q;  // stage 1, raw sync for 14-bit mode
  sensor_phase_pkg::pix_t     pack_q;  // stage 2

  always_ff @(posedge i_gclk_idata or posedge i_reset_rq) begin
    if (i_reset_rq) begin
      di_q   <= '0;
      sync_q <= '0;
      pack_q <= '0;
      o_sdo  <= '0;
    end else begin
      di_q   <= i_di;
      sync_q <= i_sync;
      case (i_pix_mode)
        sensor_phase_pkg::mode_12: pack_q <= {di_q, 2'b00};
        sensor_phase_pkg::mode_14: pack_q <= {di_q, sync_q.vact, sync_q.hact};  // vact above hact
        default:                   pack_q <= {di_q[11:2], 4'h0};  // drop two lsbs
      endcase
      o_sdo  <= pack_q;  // stage 3
    end
  end

endmodule

// File: hdl/sensor_phase_pkg.sv
// shared widths, register map, command codes and FSM states for the sensor front end
// single clock domain on gclk_idata, APB register offsets are 4-bit byte addresses
package sensor_phase_pkg;

  // widths with a meaning
  typedef logic [11:0] raw_pix_t;   // sensor pixel as sampled from the pins
  typedef logic [13:0] pix_t;       // packed output word
  typedef logic [2:0]  phase_t;     // sync delay relative to data, in cycles
  typedef logic [13:0] line_len_t;  // programmed line length in pixels
  typedef logic [7:0]  holdoff_t;   // frame-start holdoff count
  typedef logic [3:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  typedef enum logic [1:0] {
    mode_10 = 2'd0,  // upper ten bits only
    mode_12 = 2'd1,  // all twelve bits
    mode_14 = 2'd2   // twelve bits plus raw vact/hact
  } pix_mode_t;

  typedef enum logic [1:0] {
    st_idle   = 2'd0,
    st_follow = 2'd1,  // o_shact tracks delayed hact
    st_regen  = 2'd2   // o_shact timed by line length
  } line_state_t;

  typedef enum logic [1:0] {
    cmd_nop   = 2'd0,
    cmd_inc   = 2'd1,
    cmd_dec   = 2'd2,
    cmd_reset = 2'd3
  } phase_cmd_t;

  // control fields held by the register block
  typedef struct packed {
    pix_mode_t pix_mode;
    logic      hact_regen;  // when set the line is regenerated from hact_length
    logic      en_svact;    // frame-start pulse enable
    phase_t    phase;
    line_len_t hact_length;
  } ctrl_t;

  typedef struct packed {
    logic hact;
    logic vact;
  } sync_t;

  localparam apb_addr_t addr_phase  = 4'h0;
  localparam apb_addr_t addr_mode   = 4'h4;
  localparam apb_addr_t addr_length = 4'h8;

  localparam int min_vact_period = 130;  // must fit holdoff_t
  localparam int delay_taps      = 8;    // one tap per phase value

endpackage

// File: hdl/sensor_phase_top.sv
// sensor front end on one clock, data latency 3, sync latency 3 plus phase
// output data is valid on every cycle, there is no back-pressure
`timescale 1ns/100ps

module sensor_phase_top (
  input  logic                        i_gclk_idata,
  input  logic                        i_reset_rq,
  input  logic                        i_psel,
  input  logic                        i_penable,
  input  logic                        i_pwrite,
  input  sensor_phase_pkg::apb_addr_t i_paddr,
  input  sensor_phase_pkg::apb_data_t i_pwdata,
  output sensor_phase_pkg::apb_data_t o_prdata,
  output logic                        o_pready,
  output logic                        o_pslverr,
  input  logic                        i_hact,
  input  logic                        i_vact,
  input  sensor_phase_pkg::raw_pix_t  i_di,
  output logic                        o_shact,
  output logic                        o_svact,
  output sensor_phase_pkg::pix_t      o_sdo
);

  sensor_phase_pkg::ctrl_t ctrl;
  sensor_phase_pkg::sync_t raw_sync;  // pins as a struct
  sensor_phase_pkg::sync_t dly_sync;  // after the phase delay
  logic                    line_load;
  logic                    line_done;
  logic                    frame_start;
  logic                    holdoff_ok;

  assign raw_sync.hact = i_hact;
  assign raw_sync.vact = i_vact;

  phase_regs phase_regs_inst (
    .i_gclk_idata (i_gclk_idata),
    .i_reset_rq   (i_reset_rq),
    .i_psel       (i_psel),
    .i_penable    (i_penable),
    .i_pwrite     (i_pwrite),
    .i_paddr      (i_paddr),
    .i_pwdata     (i_pwdata),
    .o_prdata     (o_prdata),
    .o_pready     (o_pready),
    .o_pslverr    (o_pslverr),
    .o_ctrl       (ctrl)
  );

  sync_delay_line sync_delay_line_inst (
    .i_gclk_idata (i_gclk_idata),
    .i_reset_rq   (i_reset_rq),
    .i_sync       (raw_sync),
    .i_phase      (ctrl.phase),
    .o_sync       (dly_sync)
  );

  pixel_packer pixel_packer_inst (
    .i_gclk_idata (i_gclk_idata),
    .i_reset_rq   (i_reset_rq),
    .i_di         (i_di),
    .i_sync       (raw_sync),
    .i_pix_mode   (ctrl.pix_mode),
    .o_sdo        (o_sdo)
  );

  line_fsm line_fsm_inst (
    .i_gclk_idata  (i_gclk_idata),
    .i_reset_rq    (i_reset_rq),
    .i_sync        (dly_sync),
    .i_hact_regen  (ctrl.hact_regen),
    .i_en_svact    (ctrl.en_svact),
    .i_line_done   (line_done),
    .i_holdoff_ok  (holdoff_ok),
    .o_shact       (o_shact),
    .o_svact       (o_svact),
    .o_line_load   (line_load),
    .o_frame_start (frame_start)
  );

  line_timer line_timer_inst (
    .i_gclk_idata  (i_gclk_idata),
    .i_reset_rq    (i_reset_rq),
    .i_line_load   (line_load),
    .i_hact_length (ctrl.hact_length),
    .i_frame_start (frame_start),
    .o_line_done   (line_done),
    .o_holdoff_ok  (holdoff_ok)
  );

endmodule

// File: hdl/sync_delay_line.sv
// phase 0 gives two registers from pins to o_sync, each phase step adds one cycle
// a phase change is picked up one cycle after the register write
`timescale 1ns/100ps

module sync_delay_line (
  input  logic                     i_gclk_idata,
  input  logic                     i_reset_rq,
  input  sensor_phase_pkg::sync_t  i_sync,   // raw hact/vact pins
  input  sensor_phase_pkg::phase_t i_phase,
  output sensor_phase_pkg::sync_t  o_sync    // delayed, registered
);

  sensor_phase_pkg::sync_t  taps_q [sensor_phase_pkg::delay_taps];  // taps_q[0] is the pin register
  sensor_phase_pkg::phase_t phase_q;                                // local copy of the select

  always_ff @(posedge i_gclk_idata or posedge i_reset_rq) begin
    if (i_reset_rq) begin
      phase_q <= '0;
      for (int i = 0; i < sensor_phase_pkg::delay_taps; i++) begin
        taps_q[i] <= '0;
      end
    end else begin
      phase_q   <= i_phase;
      taps_q[0] <= i_sync;  // sample the pins
      for (int i = 1; i < sensor_phase_pkg::delay_taps; i++) begin
        taps_q[i] <= taps_q[i-1];  // one cycle per stage
      end
    end
  end

  // selected tap goes through one more register
  always_ff @(posedge i_gclk_idata or posedge i_reset_rq) begin
    if (i_reset_rq) begin
      o_sync <= '0;
    end else begin
      o_sync <= taps_q[phase_q];
    end
  end

endmodule

// File: list.f
hdl/sensor_phase_pkg.sv
hdl/phase_regs.sv
hdl/sync_delay_line.sv
hdl/pixel_packer.sv
hdl/line_fsm.sv
hdl/line_timer.sv
hdl/sensor_phase_top.sv
testbench/sensor_phase_sva.sv
testbench/tb_sensor_phase.sv

// File: testbench/sensor_phase_cases.txt
# op p1 p2 p3 p4, all hex. 1 write: addr data - exp_err  2 read: addr - exp_err exp_data
# 3 pixels: mode count  4 hact: in_width exp_width exp_latency phase_cmd  5 vact: spacing edges - pulses
2 0 0 0 0
1 4 5 0 0
2 4 0 0 5
1 8 1234 0 0
2 8 0 0 1234
1 c 7 0 1
2 c 0 1 0
2 4 0 0 5
1 0 2 0 0
2 0 0 0 7
1 0 1 0 0
2 0 0 0 0
1 0 1 0 0
1 0 1 0 0
1 0 1 0 0
2 0 0 0 3
1 0 3 0 0
2 0 0 0 0
1 4 0 0 0
3 0 14 0 0
1 4 1 0 0
3 1 14 0 0
1 4 2 0 0
3 2 14 0 0
4 5 5 3 0
4 7 7 4 1
4 2 2 5 1
4 9 9 6 1
4 4 4 7 1
4 6 6 8 1
4 3 3 9 1
4 8 8 a 1
1 4 4 0 0
1 8 a 0 0
4 3 a 3 3
4 14 a 3 0
1 8 0 0 0
4 5 1 3 0
1 4 8 0 0
5 8c 3 0 3
5 32 4 0 2
5 81 2 0 1
5 82 2 0 2
1 4 0 0 0
5 8c 2 0 0

// File: testbench/sensor_phase_sva.sv
// bound to sensor_phase_top, checks sync output rules and the APB ready level
`timescale 1ns/100ps

module sensor_phase_sva (
  input logic i_gclk_idata,
  input logic i_reset_rq,
  input logic o_pready,
  input logic o_shact,
  input logic o_svact
);

  int fail_count = 0;

  // frame start is a one cycle pulse
  svact_single: assert property (@(posedge i_gclk_idata) disable iff (i_reset_rq)
    o_svact |=> !o_svact)
    else begin
      fail_count++;
      $error("o_svact high for two cycles");
    end

  // holdoff keeps pulses at least min_vact_period apart
  svact_spacing: assert property (@(posedge i_gclk_idata) disable iff (i_reset_rq)
    o_svact |=> !o_svact [*(sensor_phase_pkg::min_vact_period - 1)])
    else begin
      fail_count++;
      $error("o_svact pulses closer than min_vact_period");
    end

  pready_high: assert property (@(posedge i_gclk_idata) o_pready)
    else begin
      fail_count++;
      $error("o_pready dropped");
    end

  sync_low_in_reset: assert property (@(posedge i_gclk_idata) i_reset_rq |-> !o_shact && !o_svact)
    else begin
      fail_count++;
      $error("sync outputs active during reset");
    end

endmodule

bind sensor_phase_top sensor_phase_sva sensor_phase_sva_inst (
  .i_gclk_idata (i_gclk_idata),
  .i_reset_rq   (i_reset_rq),
  .o_pready     (o_pready),
  .o_shact      (o_shact),
  .o_svact      (o_svact)
);

// File: testbench/tb_sensor_phase.sv
// reads testbench/sensor_phase_cases.txt from the project root, stops at the first mismatch
// expected packing and timing follow the register and latency rules of the front end
`timescale 1ns/100ps

module tb_sensor_phase;

  logic gclk_idata, reset_rq, psel, penable, pwrite, hact, vact;
  sensor_phase_pkg::apb_addr_t paddr;
  sensor_phase_pkg::apb_data_t pwdata, prdata;
  logic pready, pslverr, shact, svact;
  sensor_phase_pkg::raw_pix_t di;
  sensor_phase_pkg::pix_t sdo;
  logic [31:0] op_q[$], p1_q[$], p2_q[$], p3_q[$], p4_q[$];
  logic [31:0] seed = 32'hfb066917;
  int cycles = 0;
  int limit = 0;  // 0 until the case file is read

  sensor_phase_top sensor_phase_top_inst (
    .i_gclk_idata (gclk_idata),
    .i_reset_rq   (reset_rq),
    .i_psel       (psel),
    .i_penable    (penable),
    .i_pwrite     (pwrite),
    .i_paddr      (paddr),
    .i_pwdata     (pwdata),
    .o_prdata     (prdata),
    .o_pready     (pready),
    .o_pslverr    (pslverr),
    .i_hact       (hact),
    .i_vact       (vact),
    .i_di         (di),
    .o_shact      (shact),
    .o_svact      (svact),
    .o_sdo        (sdo)
  );

  initial begin
    gclk_idata = 1'b0;
    forever #4 gclk_idata = ~gclk_idata;  // 8 ns period
  end

  always @(posedge gclk_idata) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("run stopped: no end after %0d cycles", limit);
      $display("Checks failed");
      $fatal(1, "timeout");
    end
  end

  // bound assertions on the top level count their failures
  always @(sensor_phase_top_inst.sensor_phase_sva_inst.fail_count) begin
    if (sensor_phase_top_inst.sensor_phase_sva_inst.fail_count != 0) begin
      $display("a bound assertion on the DUT outputs failed at %0t ns", $time);
      $display("Checks failed");
      $fatal(1, "assertion failure");
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // 10-bit keeps di[11:2] on top, 12-bit all bits, 14-bit adds vact then hact
  function automatic sensor_phase_pkg::pix_t packed_pixel(input int mode,
      input sensor_phase_pkg::raw_pix_t raw, input logic h, input logic v);
    if (mode == 1) return {raw, 2'b00};
    if (mode == 2) return {raw, v, h};
    return {raw[11:2], 4'h0};
  endfunction

  task automatic stop_on_error(input string msg);
    $display("** Error at %0t ns: %s", $time, msg);
    $display("Checks failed");
    $fatal(1, "mismatch");
  endtask

  task automatic check_pix(input sensor_phase_pkg::pix_t got, exp, input string what);
    if (got !== exp) stop_on_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_apb_data(input sensor_phase_pkg::apb_data_t got, exp, input string what);
    if (got !== exp) stop_on_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_level(input logic got, exp, input string what);
    if (got !== exp) stop_on_error($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic check_count(input int got, exp, input string what);
    if (got != exp) stop_on_error($sformatf("%s got %0d expected %0d", what, got, exp));
  endtask

  task automatic next_cycle;
    @(posedge gclk_idata);
    #1;
  endtask

  // setup cycle, access cycle sampled mid-cycle, then idle
  task automatic apb_access(input logic wr, input sensor_phase_pkg::apb_addr_t a,
      input sensor_phase_pkg::apb_data_t d, input logic exp_err, input logic chk_data,
      input sensor_phase_pkg::apb_data_t exp_data);
    next_cycle();
    psel = 1'b1;
    pwrite = wr;
    paddr = a;
    pwdata = d;
    next_cycle();
    penable = 1'b1;
    @(negedge gclk_idata);
    check_level(pready, 1'b1, "o_pready");
    check_level(pslverr, exp_err, "o_pslverr");
    if (chk_data) check_apb_data(prdata, exp_data, "o_prdata");
    next_cycle();
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic run_pixels(input int mode, input int count);
    sensor_phase_pkg::pix_t exp_q[$];
    for (int i = 0; i < count + 3; i++) begin
      next_cycle();
      if (i >= 3) check_pix(sdo, exp_q.pop_front(), "o_sdo");  // three cycles after drive
      if (i < count) begin
        seed = xorshift32(seed);
        di = seed[11:0];
        hact = seed[12];
        vact = seed[13];
        exp_q.push_back(packed_pixel(mode, seed[11:0], seed[12], seed[13]));
      end else begin
        hact = 1'b0;
        vact = 1'b0;
      end
    end
  endtask

  task automatic run_hact(input int width, exp_width, exp_lat, input logic [1:0] cmd);
    int rise;
    int seen;
    rise = -1;
    seen = 0;
    apb_access(1'b1, sensor_phase_pkg::addr_phase, cmd, 1'b0, 1'b0, '0);
    repeat (12) next_cycle();  // flush the delay line
    for (int i = 0; i < width + exp_width + 20; i++) begin
      next_cycle();
      if (shact) begin
        if (rise < 0) rise = i;
        seen++;
      end
      hact = (i < width);
    end
    check_count(rise, exp_lat, "o_shact latency");
    check_count(seen, exp_width, "o_shact width");
  endtask

  task automatic run_vact(input int spacing, input int edges, input int exp_pulses);
    int pulses;
    pulses = 0;
    repeat (140) next_cycle();  // let the holdoff expire
    for (int e = 0; e < edges; e++) begin
      for (int i = 0; i < spacing; i++) begin
        next_cycle();
        if (svact) pulses++;
        vact = (i < 4);
      end
    end
    repeat (16) begin
      next_cycle();
      if (svact) pulses++;
    end
    check_count(pulses, exp_pulses, "o_svact pulse count");
  endtask

  initial begin
    int fd;
    int n;
    string line;
    logic [31:0] f[5];
    {reset_rq, psel, penable, pwrite, hact, vact} = 6'b100000;
    paddr = '0;
    pwdata = '0;
    di = '0;
    fd = $fopen("testbench/sensor_phase_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open the case file testbench/sensor_phase_cases.txt");
      $display("Checks failed");
      $fatal(1, "no case file");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1 && line[0] != "#" && $sscanf(line, "%h %h %h %h %h", f[0], f[1], f[2],
          f[3], f[4]) == 5) begin
        op_q.push_back(f[0]);
        p1_q.push_back(f[1]);
        p2_q.push_back(f[2]);
        p3_q.push_back(f[3]);
        p4_q.push_back(f[4]);
        case (f[0])
          3: limit += f[2] + 4;
          4: limit += f[1] + f[2] + 60;
          5: limit += 160 + f[1] * f[2];
          default: limit += 4;
        endcase
      end
    end
    $fclose(fd);
    limit += 200;
    repeat (3) @(posedge gclk_idata);
    #1 reset_rq = 1'b0;
    check_level(shact, 1'b0, "o_shact after reset");
    check_level(svact, 1'b0, "o_svact after reset");
    check_pix(sdo, '0, "o_sdo after reset");
    foreach (op_q[k]) begin
      case (op_q[k])
        1: apb_access(1'b1, p1_q[k], p2_q[k], p4_q[k][0], 1'b0, '0);
        2: apb_access(1'b0, p1_q[k], '0, p3_q[k][0], 1'b1, p4_q[k]);
        3: run_pixels(p1_q[k], p2_q[k]);
        4: run_hact(p1_q[k], p2_q[k], p3_q[k], p4_q[k][1:0]);
        5: run_vact(p1_q[k], p2_q[k], p4_q[k]);
        default: stop_on_error($sformatf("unknown operation %0d in case %0d", op_q[k], k));
      endcase
    end
    $display("All checks passed");
    $finish;
  end

endmodule
